/* Bender.yml */
package:
  name: axil_apb

sources:
  - axil_apb_pkg.sv
  - rr_arb.sv
  - axil2apb_bridge.sv
  - apb_timer_regs.sv
  - timer_core.sv
  - axil_apb_top.sv
  - target: test
    files:
      - tb_axil_apb_top.sv

/* apb_timer_regs.sv */
`timescale 1ns/10ps

module apb_timer_regs import axil_apb_pkg::*; (
  input  logic        clk,
  input  logic        arst_n,
  input  apb_req_t    apb_req,
  output apb_rsp_t    apb_rsp,
  output timer_cfg_t  cfg,
  input  timer_stat_t stat,
  output logic        irq
);

  // Register contents
  logic                  en_q;
  logic                  reload_q;
  logic [DATA_WIDTH-1:0] load_q;
  logic                  load_stb_q;
  logic                  expired_q;

  // Decode
  logic sel_ctrl;
  logic sel_load;
  logic sel_count;
  logic sel_status;
  logic misaligned;
  logic err;
  logic wr_en;
  logic clr_expired;

  logic [DATA_WIDTH-1:0] rdata;

  // --------------------
  // Address decode
  // --------------------
  // Word decode, the byte offset is judged on its own
  assign sel_ctrl   = (apb_req.paddr[ADDR_WIDTH-1:2] == REG_CTRL[ADDR_WIDTH-1:2]);
  assign sel_load   = (apb_req.paddr[ADDR_WIDTH-1:2] == REG_LOAD[ADDR_WIDTH-1:2]);
  assign sel_count  = (apb_req.paddr[ADDR_WIDTH-1:2] == REG_COUNT[ADDR_WIDTH-1:2]);
  assign sel_status = (apb_req.paddr[ADDR_WIDTH-1:2] == REG_STATUS[ADDR_WIDTH-1:2]);
  assign misaligned = |apb_req.paddr[1:0];

  // Unmapped, misaligned or a write to the read-only counter
  assign err = misaligned
             || !(sel_ctrl || sel_load || sel_count || sel_status)
             || (apb_req.pwrite && sel_count);

  // Writes land on the access-phase edge and only when clean
  assign wr_en = apb_req.psel && apb_req.penable && apb_req.pwrite && !err;

  // W1C on the expired flag, byte 0 carries it
  assign clr_expired = wr_en && sel_status && apb_req.pstrb[0]
                    && apb_req.pwdata[STAT_EXP_BIT];

  // --------------------
  // Register updates
  // --------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      en_q       <= 1'b0;
      reload_q   <= 1'b0;
      load_q     <= '0;
      load_stb_q <= 1'b0;
      expired_q  <= 1'b0;
    end else begin
      // One-shot stop from the timer drops enable
      if (stat.stop) begin
        en_q <= 1'b0;
      end
      // A CTRL write in the same cycle overrides the stop
      if (wr_en && sel_ctrl && apb_req.pstrb[0]) begin
        en_q     <= apb_req.pwdata[CTRL_EN_BIT];
        reload_q <= apb_req.pwdata[CTRL_RELOAD_BIT];
      end
      // Byte-merged LOAD
      if (wr_en && sel_load) begin
        for (int i = 0; i < STRB_WIDTH; i++) begin
          if (apb_req.pstrb[i]) begin
            load_q[8*i +: 8] <= apb_req.pwdata[8*i +: 8];
          end
        end
      end
      // Strobe follows the write so the timer sees the new value
      load_stb_q <= wr_en && sel_load;
      // Set beats clear
      if (stat.expire) begin
        expired_q <= 1'b1;
      end else if (clr_expired) begin
        expired_q <= 1'b0;
      end
    end
  end

  // --------------------
  // Read path
  // --------------------
  always_comb begin
    rdata = '0;
    if (sel_ctrl) begin
      rdata[CTRL_EN_BIT]     = en_q;
      rdata[CTRL_RELOAD_BIT] = reload_q;
    end else if (sel_load) begin
      rdata = load_q;
    end else if (sel_count) begin
      rdata = stat.count;
    end else if (sel_status) begin
      rdata[STAT_EXP_BIT] = expired_q;
    end
  end

  // Zero-wait slave
  assign apb_rsp.prdata  = rdata;
  assign apb_rsp.pready  = 1'b1;
  assign apb_rsp.pslverr = apb_req.psel && err;

  // Timer steering
  assign cfg.enable      = en_q;
  assign cfg.auto_reload = reload_q;
  assign cfg.load        = load_q;
  assign cfg.load_stb    = load_stb_q;

  assign irq = expired_q;

endmodule

/* axil2apb_bridge.sv */
`timescale 1ns/10ps

module axil2apb_bridge import axil_apb_pkg::*; (
  input  logic                  clk,
  input  logic                  arst_n,
  // AXI4-Lite write side
  input  axil_aw_t              aw,
  input  logic                  aw_valid,
  output logic                  aw_ready,
  input  axil_w_t               w,
  input  logic                  w_valid,
  output logic                  w_ready,
  output logic [RESP_WIDTH-1:0] b_resp,
  output logic                  b_valid,
  input  logic                  b_ready,
  // AXI4-Lite read side
  input  axil_aw_t              ar,
  input  logic                  ar_valid,
  output logic                  ar_ready,
  output logic [DATA_WIDTH-1:0] r_data,
  output logic [RESP_WIDTH-1:0] r_resp,
  output logic                  r_valid,
  input  logic                  r_ready,
  // APB master side
  output apb_req_t              apb_req,
  input  apb_rsp_t              apb_rsp
);

  // One-hot phase encoding
  typedef enum logic [3:0] {
    ST_IDLE   = 4'b0001,
    ST_SETUP  = 4'b0010,
    ST_ACCESS = 4'b0100,
    ST_RESP   = 4'b1000
  } state_t;

  state_t state_q;
  state_t state_d;

  // Captured request
  logic [ADDR_WIDTH-1:0] addr_q;
  logic [PROT_WIDTH-1:0] prot_q;
  logic [DATA_WIDTH-1:0] data_q;
  logic [STRB_WIDTH-1:0] strb_q;
  logic                  write_q;
  // Captured completion
  logic [DATA_WIDTH-1:0] rdata_q;
  logic                  err_q;

  logic       is_idle;
  logic       done;
  logic       any_grant;
  logic [1:0] arb_req;
  logic [1:0] arb_grant;

  // --------------------
  // Arbitration
  // --------------------
  assign is_idle = (state_q == ST_IDLE);

  // Bit 1 is the write, bit 0 the read
  assign arb_req[1] = aw_valid && w_valid && is_idle;
  assign arb_req[0] = ar_valid && is_idle;

  rr_arb u_arb (
    .clk   (clk),
    .arst_n(arst_n),
    .req   (arb_req),
    .grant (arb_grant)
  );

  assign any_grant = |arb_grant;

  assign aw_ready = arb_grant[1];
  assign w_ready  = arb_grant[1];
  assign ar_ready = arb_grant[0];

  // Access phase ends once the slave is ready
  assign done = (state_q == ST_ACCESS) && apb_rsp.pready;

  // --------------------
  // Phase sequencing
  // --------------------
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ST_IDLE: begin
        if (any_grant) begin
          state_d = ST_SETUP;
        end
      end
      ST_SETUP: begin
        state_d = ST_ACCESS;
      end
      ST_ACCESS: begin
        if (apb_rsp.pready) begin
          state_d = ST_RESP;
        end
      end
      ST_RESP: begin
        // Wait for the master to take the response
        if ((write_q && b_ready) || (!write_q && r_ready)) begin
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= ST_IDLE;
      write_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (any_grant) begin
        write_q <= arb_grant[1];
      end
    end
  end

  // Request capture on the accept cycle
  always_ff @(posedge clk) begin
    if (any_grant) begin
      addr_q <= arb_grant[1] ? aw.addr : ar.addr;
      prot_q <= arb_grant[1] ? aw.prot : ar.prot;
      data_q <= w.data;
      strb_q <= w.strb;
    end
  end

  // Completion capture
  always_ff @(posedge clk) begin
    if (done) begin
      rdata_q <= apb_rsp.prdata;
      err_q   <= apb_rsp.pslverr;
    end
  end

  // --------------------
  // Outputs
  // --------------------
  assign apb_req.paddr   = addr_q;
  assign apb_req.psel    = (state_q == ST_SETUP) || (state_q == ST_ACCESS);
  assign apb_req.penable = (state_q == ST_ACCESS);
  assign apb_req.pwrite  = write_q;
  assign apb_req.pwdata  = data_q;
  // Strobes stay low on reads
  assign apb_req.pstrb   = write_q ? strb_q : '0;
  assign apb_req.pprot   = prot_q;

  assign b_valid = (state_q == ST_RESP) && write_q;
  assign b_resp  = err_q ? RESP_SLVERR : RESP_OKAY;
  assign r_valid = (state_q == ST_RESP) && !write_q;
  assign r_resp  = err_q ? RESP_SLVERR : RESP_OKAY;
  assign r_data  = rdata_q;

endmodule

/* axil_apb_pkg.sv */
package axil_apb_pkg;

  // --------------------
  // Bus widths
  // --------------------
  localparam int ADDR_WIDTH = 12;
  localparam int DATA_WIDTH = 32;
  localparam int STRB_WIDTH = DATA_WIDTH / 8;
  localparam int PROT_WIDTH = 3;
  localparam int RESP_WIDTH = 2;

  // AXI response codes
  localparam logic [RESP_WIDTH-1:0] RESP_OKAY   = 2'b00;
  localparam logic [RESP_WIDTH-1:0] RESP_SLVERR = 2'b10;

  // --------------------
  // Register map
  // --------------------
  localparam logic [ADDR_WIDTH-1:0] REG_CTRL   = 12'h000;
  localparam logic [ADDR_WIDTH-1:0] REG_LOAD   = 12'h004;
  // Read-only
  localparam logic [ADDR_WIDTH-1:0] REG_COUNT  = 12'h008;
  localparam logic [ADDR_WIDTH-1:0] REG_STATUS = 12'h00C;

  // Bit positions inside CTRL and STATUS
  localparam int CTRL_EN_BIT     = 0;
  localparam int CTRL_RELOAD_BIT = 1;
  localparam int STAT_EXP_BIT    = 0;

  // --------------------
  // Channel structs
  // --------------------
  // Shared by AW and AR
  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;
    logic [PROT_WIDTH-1:0] prot;
  } axil_aw_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic [STRB_WIDTH-1:0] strb;
  } axil_w_t;

  typedef struct packed {
    logic [ADDR_WIDTH-1:0] paddr;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [DATA_WIDTH-1:0] pwdata;
    logic [STRB_WIDTH-1:0] pstrb;
    logic [PROT_WIDTH-1:0] pprot;
  } apb_req_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] prdata;
    logic                  pready;
    logic                  pslverr;
  } apb_rsp_t;

  // Register block to timer
  typedef struct packed {
    logic                  enable;
    logic                  auto_reload;
    logic [DATA_WIDTH-1:0] load;
    logic                  load_stb;
  } timer_cfg_t;

  // Timer back to register block
  typedef struct packed {
    logic [DATA_WIDTH-1:0] count;
    logic                  expire;
    logic                  stop;
  } timer_stat_t;

endpackage

/* axil_apb_top.sv */
`timescale 1ns/10ps

module axil_apb_top import axil_apb_pkg::*; (
  input  logic                  clk,
  input  logic                  arst_n,
  input  axil_aw_t              aw,
  input  logic                  aw_valid,
  output logic                  aw_ready,
  input  axil_w_t               w,
  input  logic                  w_valid,
  output logic                  w_ready,
  output logic [RESP_WIDTH-1:0] b_resp,
  output logic                  b_valid,
  input  logic                  b_ready,
  input  axil_aw_t              ar,
  input  logic                  ar_valid,
  output logic                  ar_ready,
  output logic [DATA_WIDTH-1:0] r_data,
  output logic [RESP_WIDTH-1:0] r_resp,
  output logic                  r_valid,
  input  logic                  r_ready,
  output logic                  irq
);

  // Internal links
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;
  timer_cfg_t  cfg;
  timer_stat_t stat;

  // AXI4-Lite to APB
  axil2apb_bridge u_bridge (
    .clk     (clk),
    .arst_n  (arst_n),
    .aw      (aw),
    .aw_valid(aw_valid),
    .aw_ready(aw_ready),
    .w       (w),
    .w_valid (w_valid),
    .w_ready (w_ready),
    .b_resp  (b_resp),
    .b_valid (b_valid),
    .b_ready (b_ready),
    .ar      (ar),
    .ar_valid(ar_valid),
    .ar_ready(ar_ready),
    .r_data  (r_data),
    .r_resp  (r_resp),
    .r_valid (r_valid),
    .r_ready (r_ready),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp)
  );

  // Single APB slave, no decoder
  apb_timer_regs u_regs (
    .clk    (clk),
    .arst_n (arst_n),
    .apb_req(apb_req),
    .apb_rsp(apb_rsp),
    .cfg    (cfg),
    .stat   (stat),
    .irq    (irq)
  );

  timer_core u_timer (
    .clk   (clk),
    .arst_n(arst_n),
    .cfg   (cfg),
    .stat  (stat)
  );

endmodule

/* flist.f */
axil_apb_pkg.sv
rr_arb.sv
axil2apb_bridge.sv
apb_timer_regs.sv
timer_core.sv
axil_apb_top.sv
tb_axil_apb_top.sv

/* rr_arb.sv */
`timescale 1ns/10ps

module rr_arb import axil_apb_pkg::*; (
  input  logic       clk,
  input  logic       arst_n,
  input  logic [1:0] req,
  output logic [1:0] grant
);

  // High when requester 1 (write) took the last grant
  logic last_wr_q;

  // Combinational grant, one winner at most
  always_comb begin
    grant = 2'b00;
    unique case (req)
      2'b01: grant = 2'b01;
      2'b10: grant = 2'b10;
      // Contention goes to whoever lost last time
      2'b11: grant = last_wr_q ? 2'b01 : 2'b10;
      default: grant = 2'b00;
    endcase
  end

  // Remember the winner, reset favours the write side
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      last_wr_q <= 1'b0;
    end else if (|grant) begin
      last_wr_q <= grant[1];
    end
  end

endmodule

/* tb_axil_apb_top.sv */
`timescale 1ns/10ps

module tb_axil_apb_top import axil_apb_pkg::*; ();

  // Rough transaction budget for the watchdog
  localparam int N_TXN     = 100;
  localparam int WD_CYCLES = N_TXN * 40 + 2000;

  typedef enum logic [1:0] {RD_EXACT, RD_ANY, RD_COUNT} rd_mode_t;

  logic clk;
  logic arst_n;
  axil_aw_t aw, ar;
  axil_w_t w;
  logic aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
  logic ar_valid, ar_ready, r_valid, r_ready, irq;
  logic [RESP_WIDTH-1:0] b_resp, r_resp;
  logic [DATA_WIDTH-1:0] r_data;

  // Reference model of CTRL, LOAD and STATUS
  logic [1:0]  ctrl_m = '0;
  logic [31:0] load_m = '0;
  logic        status_m = 1'b0;
  // Expected responses
  logic [RESP_WIDTH-1:0] exp_bresp = RESP_OKAY;
  logic [RESP_WIDTH-1:0] exp_rresp = RESP_OKAY;
  logic [31:0] exp_rdata = '0;
  logic [31:0] last_count = '1;
  rd_mode_t    rd_mode = RD_EXACT;
  logic        irq_check = 1'b0;
  logic        exp_irq = 1'b0;
  // Bus activity seen at the falling edge, then folded in at the rising edge
  logic acc_wr_n = 1'b0;
  logic acc_rd_n = 1'b0;
  logic resp_n = 1'b0;
  logic busy;
  logic last_wr_m;
  logic [31:0] seed = 32'h302d;
  // Back-pressure draw, taken at the falling edge
  logic [31:0] bp_rand = '0;

  axil_apb_top DUT (.*);

  always #10 clk = ~clk;

  // --------------------
  // Helpers
  // --------------------
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function logic [31:0] next_rand();
    seed = xorshift(seed);
    return seed;
  endfunction

  // Unmapped, misaligned, or a write to COUNT
  function automatic logic is_bad(input logic [11:0] a, input logic wr);
    return (a[1:0] != 2'b00) || (a > REG_STATUS) || (wr && a == REG_COUNT);
  endfunction

  function automatic logic [31:0] model_read(input logic [11:0] a);
    case (a)
      REG_CTRL:   return {30'b0, ctrl_m};
      REG_LOAD:   return load_m;
      REG_STATUS: return {31'b0, status_m};
      default:    return 32'b0;
    endcase
  endfunction

  task automatic update_model(input logic [11:0] a, input logic [31:0] d, input logic [3:0] s);
    if (a == REG_CTRL && s[0]) ctrl_m = d[1:0];
    if (a == REG_STATUS && s[0] && d[0]) status_m = 1'b0;
    if (a == REG_LOAD) begin
      for (int i = 0; i < 4; i++) begin
        if (s[i]) load_m[8*i +: 8] = d[8*i +: 8];
      end
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic report_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    $display("[ERROR] %0d ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
    abort_run("Check on a DUT output failed");
  endtask

  // --------------------
  // AXI4-Lite stimulus
  // --------------------
  task automatic axil_write(input logic [11:0] a, input logic [31:0] d, input logic [3:0] s);
    logic bad;
    bad = is_bad(a, 1'b1);
    exp_bresp = bad ? RESP_SLVERR : RESP_OKAY;
    @(posedge clk);
    aw.addr  <= a;
    aw.prot  <= d[2:0];
    w.data   <= d;
    w.strb   <= s;
    aw_valid <= 1'b1;
    w_valid  <= 1'b1;
    @(negedge clk);
    while (!aw_ready) @(negedge clk);
    @(posedge clk);
    aw_valid <= 1'b0;
    w_valid  <= 1'b0;
    @(negedge clk);
    while (!(b_valid && b_ready)) @(negedge clk);
    @(posedge clk);
    if (!bad) update_model(a, d, s);
  endtask

  task automatic axil_read(input logic [11:0] a, input rd_mode_t mode, input logic [31:0] exp,
                           output logic [31:0] d);
    rd_mode   = mode;
    exp_rdata = exp;
    exp_rresp = is_bad(a, 1'b0) ? RESP_SLVERR : RESP_OKAY;
    @(posedge clk);
    ar.addr  <= a;
    ar.prot  <= 3'b000;
    ar_valid <= 1'b1;
    @(negedge clk);
    while (!ar_ready) @(negedge clk);
    @(posedge clk);
    ar_valid <= 1'b0;
    @(negedge clk);
    while (!(r_valid && r_ready)) @(negedge clk);
    d = r_data;
    @(posedge clk);
  endtask

  // Write and read of LOAD presented in the same cycle
  task automatic write_read_pair(input logic [31:0] wd);
    logic [31:0] exp;
    logic [31:0] d;
    // Write goes first unless it won last time
    exp = last_wr_m ? load_m : wd;
    fork
      axil_write(REG_LOAD, wd, 4'hF);
      axil_read(REG_LOAD, RD_EXACT, exp, d);
    join
  endtask

  // Draw away from the rising edge where the sequence draws its data
  always @(negedge clk) begin
    bp_rand = next_rand();
  end

  // Random back-pressure on both response channels
  always @(posedge clk) begin
    b_ready <= |bp_rand[1:0];
    r_ready <= |bp_rand[3:2];
  end

  // Accepts and handshakes are stable at the falling edge
  always @(negedge clk) begin
    acc_wr_n = aw_valid && aw_ready;
    acc_rd_n = ar_valid && ar_ready;
    resp_n   = (b_valid && b_ready) || (r_valid && r_ready);
  end

  // Busy flag and last arbitration winner, reset favours the write
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy      <= 1'b0;
      last_wr_m <= 1'b0;
    end else if (acc_wr_n || acc_rd_n) begin
      busy      <= 1'b1;
      last_wr_m <= acc_wr_n;
    end else if (resp_n) begin
      busy <= 1'b0;
    end
  end

  // --------------------
  // Assertions
  // --------------------
  a_reset: assert property (@(posedge clk) !arst_n |->
    !aw_ready && !w_ready && !ar_ready && !b_valid && !r_valid && !irq)
    else abort_run("An AXI ready, valid or irq output was high during reset");
  a_wready: assert property (@(posedge clk) disable iff (!arst_n) aw_ready == w_ready)
    else report_value("w_ready", $sampled(aw_ready), $sampled(w_ready));
  a_bresp: assert property (@(posedge clk) disable iff (!arst_n) b_valid |-> b_resp == exp_bresp)
    else report_value("b_resp", exp_bresp, $sampled(b_resp));
  a_rresp: assert property (@(posedge clk) disable iff (!arst_n) r_valid |-> r_resp == exp_rresp)
    else report_value("r_resp", exp_rresp, $sampled(r_resp));
  a_rdata: assert property (@(posedge clk) disable iff (!arst_n)
    r_valid && rd_mode == RD_EXACT |-> r_data == exp_rdata)
    else report_value("r_data", exp_rdata, $sampled(r_data));
  a_count: assert property (@(posedge clk) disable iff (!arst_n)
    r_valid && rd_mode == RD_COUNT |-> r_data <= last_count)
    else report_value("r_data (COUNT above previous read)", last_count, $sampled(r_data));
  a_wlat: assert property (@(posedge clk) disable iff (!arst_n)
    aw_valid && aw_ready |=> !b_valid ##1 !b_valid ##1 b_valid)
    else abort_run("b_valid did not rise exactly 3 cycles after the write accept");
  a_rlat: assert property (@(posedge clk) disable iff (!arst_n)
    ar_valid && ar_ready |=> !r_valid ##1 !r_valid ##1 r_valid)
    else abort_run("r_valid did not rise exactly 3 cycles after the read accept");
  a_bhold: assert property (@(posedge clk) disable iff (!arst_n)
    b_valid && !b_ready |=> b_valid && $stable(b_resp))
    else abort_run("Write response dropped or changed while b_ready was low");
  a_rhold: assert property (@(posedge clk) disable iff (!arst_n)
    r_valid && !r_ready |=> r_valid && $stable(r_data) && $stable(r_resp))
    else abort_run("Read response dropped or changed while r_ready was low");
  a_busy: assert property (@(posedge clk) disable iff (!arst_n) busy |-> !aw_ready && !ar_ready)
    else abort_run("A new request was accepted before the response handshake");
  a_arb: assert property (@(posedge clk) disable iff (!arst_n)
    aw_valid && w_valid && ar_valid && (aw_ready || ar_ready) |-> aw_ready == !last_wr_m)
    else report_value("aw_ready", !last_wr_m, $sampled(aw_ready));
  a_irq: assert property (@(posedge clk) disable iff (!arst_n) irq_check |-> irq == exp_irq)
    else report_value("irq", exp_irq, $sampled(irq));

  // --------------------
  // Test sequence
  // --------------------
  initial begin
    logic [31:0] d;
    logic [31:0] rv;
    logic [11:0] a;
    clk = 1'b0;
    arst_n = 1'b0;
    aw = '0;
    ar = '0;
    w = '0;
    aw_valid = 1'b0;
    w_valid = 1'b0;
    ar_valid = 1'b0;
    b_ready = 1'b0;
    r_ready = 1'b0;
    repeat (10) @(posedge clk);
    arst_n <= 1'b1;
    irq_check <= 1'b1;
    // Reset values
    axil_read(REG_CTRL, RD_EXACT, 32'h0, d);
    axil_read(REG_LOAD, RD_EXACT, 32'h0, d);
    axil_read(REG_COUNT, RD_EXACT, 32'h0, d);
    axil_read(REG_STATUS, RD_EXACT, 32'h0, d);
    // Byte-merged register access, enable kept clear
    for (int i = 0; i < 16; i++) begin
      rv = next_rand();
      a = rv[31] ? REG_LOAD : REG_CTRL;
      axil_write(a, next_rand() & 32'hFFFF_FFFE, rv[3:0]);
      axil_read(a, RD_EXACT, model_read(a), d);
    end
    // Error responses leave the model untouched
    axil_write(REG_COUNT, next_rand(), 4'hF);
    rv = next_rand();
    axil_write(12'h010 | {rv[11:2], 2'b00}, next_rand(), 4'hF);
    axil_write(REG_LOAD | 12'h001, next_rand(), 4'hF);
    axil_read(12'h7F0, RD_ANY, 32'h0, d);
    axil_read(REG_LOAD, RD_EXACT, model_read(REG_LOAD), d);
    axil_read(REG_CTRL, RD_EXACT, model_read(REG_CTRL), d);
    // Simultaneous requests in both orders
    write_read_pair(next_rand());
    axil_write(REG_CTRL, 32'h0, 4'h1);
    write_read_pair(next_rand());
    axil_read(REG_CTRL, RD_EXACT, model_read(REG_CTRL), d);
    write_read_pair(next_rand());
    // One-shot timer
    irq_check <= 1'b0;
    axil_write(REG_LOAD, 32'd40, 4'hF);
    last_count = 32'd40;
    axil_write(REG_CTRL, 32'h1, 4'h1);
    rv = '0;
    while (!rv[0]) begin
      axil_read(REG_COUNT, RD_COUNT, 32'h0, d);
      last_count = d;
      axil_read(REG_STATUS, RD_ANY, 32'h0, rv);
    end
    status_m = 1'b1;
    ctrl_m[0] = 1'b0;
    exp_irq <= 1'b1;
    irq_check <= 1'b1;
    axil_read(REG_CTRL, RD_EXACT, model_read(REG_CTRL), d);
    irq_check <= 1'b0;
    axil_write(REG_STATUS, 32'h1, 4'h1);
    exp_irq <= 1'b0;
    irq_check <= 1'b1;
    axil_read(REG_STATUS, RD_EXACT, model_read(REG_STATUS), d);
    // Periodic timer raises irq again after a clear
    irq_check <= 1'b0;
    axil_write(REG_LOAD, 32'd60, 4'hF);
    axil_write(REG_CTRL, 32'h3, 4'h1);
    @(negedge clk);
    while (!irq) @(negedge clk);
    status_m = 1'b1;
    axil_write(REG_STATUS, 32'h1, 4'h1);
    irq_check <= 1'b1;
    repeat (10) @(posedge clk);
    irq_check <= 1'b0;
    @(negedge clk);
    while (!irq) @(negedge clk);
    $display("ALL TESTS PASSED");
    $finish;
  end

  // Watchdog
  initial begin
    repeat (WD_CYCLES) @(posedge clk);
    abort_run("Watchdog timeout: the test sequence did not finish in time");
  end

endmodule

/* timer_core.sv */
`timescale 1ns/10ps

module timer_core import axil_apb_pkg::*; (
  input  logic        clk,
  input  logic        arst_n,
  input  timer_cfg_t  cfg,
  output timer_stat_t stat
);

  logic [DATA_WIDTH-1:0] count_q;
  logic                  at_zero;
  logic                  expire;

  assign at_zero = (count_q == '0);

  // Expiry in each enabled cycle at zero, a pending load takes over
  assign expire = cfg.enable && at_zero && !cfg.load_stb;

  // --------------------
  // Down counter
  // --------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      count_q <= '0;
    end else if (cfg.load_stb) begin
      count_q <= cfg.load;
    end else if (expire && cfg.auto_reload) begin
      // Periodic mode restarts on the expiry edge
      count_q <= cfg.load;
    end else if (cfg.enable && !at_zero) begin
      count_q <= count_q - 1'b1;
    end
  end

  // Status back to the register block
  assign stat.count  = count_q;
  assign stat.expire = expire;
  // One-shot mode asks for enable to drop
  assign stat.stop   = expire && !cfg.auto_reload;

endmodule
